//--- vlog.f
+incdir+include
src/sub86Pkg.sv
src/busSampler.sv
src/regionDecoder.sv
src/irqWatchdog.sv
src/busOutputStage.sv
src/cus47Top.sv
bench/cus47Tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = cus47Tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/cus47Tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sub86_macros.svh"

module cus47Tb import sub86Pkg::*; ();

	//////////////////////////////////////////////////////////////////////
	// Run layout in clk6M cycles
	//////////////////////////////////////////////////////////////////////

	localparam int resetCycles = 8;
	localparam int idleCycles  = 4;
	localparam int firstCheck  = resetCycles + idleCycles;
	localparam int phaseBStart = firstCheck + 1200;
	localparam int phaseCStart = phaseBStart + 600;
	localparam int totalCycles = phaseCStart + 400;
	localparam int timeoutNs   = totalCycles * 10 + 1000;

	// Kick window 8000h and acknowledge window 8400h
	localparam logic [`ADDR_HI:`ADDR_LO] kickSlice = 6'h20;
	localparam logic [`ADDR_HI:`ADDR_LO] ackSlice  = 6'h21;

	// Unkicked falls that set the counter top bit
	localparam int expireCount = 1 << (`WATCHDOG_WIDTH - 1);

	// One cycle of driven inputs
	typedef struct packed {
		logic                     clk2H;
		logic                     nWe;
		logic                     nVblk;
		logic [`ADDR_HI:`ADDR_LO] addr;
	} drive_t;

	logic                     clk6M, rst, clk2H, nWe, nVblk;
	logic [`ADDR_HI:`ADDR_LO] addr;
	wire                      nRes, nIrq, mq, me, subE, subQ;
	wire                      nScr0, nScr1, nObj, nSnd, nSpgm, nMpgm;
	wire                      bank, nLth0, nLth1, nLth2, nBufEn;

	// Newest drive at index 0
	drive_t hist[$];
	// Model state after the latest edge
	logic   modelIrqN;
	int     modelCnt;
	// Vblank pacing and the pending ack write
	int     vblkTimer;
	int     ackDue;

	cus47Top cus47Top_i (.*);

	initial begin
		clk6M = 1'b0;
		forever #5 clk6M = ~clk6M;
	end

	// Run length limit
	initial begin
		#(timeoutNs);
		abortRun("simulation timed out");
	end

	//////////////////////////////////////////////////////////////////////
	// Failure and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("SOME TESTS FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic checkSel(input sel_t expSel, input sel_t actSel,
		input logic expBuf, input logic actBuf);
		if (actSel !== expSel) begin
			$display("Error sel expected 0x%h actual 0x%h", expSel, actSel);
			abortRun("chip select mismatch");
		end
		if (actBuf !== expBuf) begin
			$display("Error nBufEn expected 0x%h actual 0x%h", expBuf, actBuf);
			abortRun("buffer enable mismatch");
		end
	endtask

	// Phase order is me, subE, mq, subQ
	task automatic checkPhase(input logic [3:0] expPh, input logic [3:0] actPh);
		if (actPh !== expPh) begin
			$display("Error {me,subE,mq,subQ} expected 0x%h actual 0x%h", expPh, actPh);
			abortRun("CPU clock phase mismatch");
		end
	endtask

	task automatic checkIrq(input logic expIrq, input logic actIrq);
		if (actIrq !== expIrq) begin
			$display("Error nIrq expected 0x%h actual 0x%h", expIrq, actIrq);
			abortRun("interrupt line mismatch");
		end
	endtask

	task automatic checkRes(input logic expRes, input logic actRes);
		if (actRes !== expRes) begin
			$display("Error nRes expected 0x%h actual 0x%h", expRes, actRes);
			abortRun("reset line mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory map model
	//////////////////////////////////////////////////////////////////////

	function automatic sel_t expectedSel(input logic [`ADDR_HI:`ADDR_LO] slice);
		logic [15:0] base;
		sel_t        s;
		base   = {slice, {`ADDR_LO{1'b0}}};
		s.scr0 = base < 16'h2000;
		s.scr1 = base >= 16'h2000 && base < 16'h4000;
		s.obj  = base >= 16'h4000 && base < 16'h6000;
		// Sound RAM overlaps the first KB of sprite RAM
		s.snd  = base >= 16'h4000 && base < 16'h4400;
		s.spgm = base >= 16'h6000 && base < 16'h8000;
		s.mpgm = base >= 16'h8000;
		// Latches sit inside the main ROM range
		s.bank = base >= 16'h8C00 && base < 16'h9000;
		s.lth0 = base >= 16'h9000 && base < 16'h9400;
		s.lth1 = base >= 16'h9400 && base < 16'h9800;
		s.lth2 = base >= 16'hA000 && base < 16'hA400;
		return s;
	endfunction

	function automatic region_e classify(input logic [`ADDR_HI:`ADDR_LO] slice);
		logic [15:0] base;
		base = {slice, {`ADDR_LO{1'b0}}};
		if (base == 16'h8400) return regIrqAck;
		if (base >= 16'h8000 && base < 16'h8400) return regWdogKick;
		return regOther;
	endfunction

	// DUT selects turned back to active high
	function automatic sel_t readSel();
		return {~nScr0, ~nScr1, ~nObj, ~nSnd, ~nSpgm, ~nMpgm, bank, ~nLth0, ~nLth1, ~nLth2};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and per-cycle checking
	//////////////////////////////////////////////////////////////////////

	task automatic pickInputs(input int cycle, output drive_t d);
		logic [31:0] rnd;
		rnd     = $urandom;
		d.addr  = rnd[`ADDR_HI-`ADDR_LO:0];
		d.nWe   = rnd[8];
		d.clk2H = 1'b0;
		d.nVblk = 1'b1;
		if (cycle < firstCheck) begin
			// Quiet bus through reset and settling
			d.nWe = 1'b1;
		end else begin
			// 2H toggles every second cycle
			d.clk2H = cycle[1];
			// Four cycles of vblank, period 37 to 44
			if (vblkTimer == 0) begin
				vblkTimer = 36 + int'(rnd[14:12]);
			end else begin
				vblkTimer--;
			end
			d.nVblk = (vblkTimer >= 4);
			// Ack in the very fall cycle, or a few cycles later
			if (vblkTimer == 3) begin
				if (rnd[17:16] == 2'b00) ackDue = cycle;
				else ackDue = cycle + 6 + int'(rnd[23:20]);
			end
			if (cycle == ackDue) begin
				d.addr = ackSlice;
				d.nWe  = 1'b0;
			end
			// Phase B lets the watchdog run out
			if (cycle > phaseBStart && cycle < phaseCStart && d.addr == kickSlice) begin
				d.nWe = 1'b1;
			end
			// Scheduled kicks, well inside one vblank period
			if (cycle == phaseBStart || cycle == phaseCStart ||
				((cycle < phaseBStart || cycle > phaseCStart) && cycle % 24 == 0)) begin
				d.addr = kickSlice;
				d.nWe  = 1'b0;
			end
		end
	endtask

	// Outputs after edge k reflect the drive of edge k-2, subE that of k-3
	task automatic checkCycle();
		drive_t  d2;
		drive_t  d3;
		logic    fall;
		logic    wr;
		region_e win;
		sel_t    expSel;
		d2   = hist[2];
		d3   = hist[3];
		fall = d3.nVblk & ~d2.nVblk;
		wr   = ~d2.nWe;
		win  = classify(d2.addr);
		// Set wins over a same-cycle ack
		if (fall) modelIrqN = 1'b0;
		else if (wr && win == regIrqAck) modelIrqN = 1'b1;
		// Kick wins over a same-cycle fall, count holds once expired
		if (wr && win == regWdogKick) modelCnt = 0;
		else if (fall && modelCnt < expireCount) modelCnt++;
		expSel = expectedSel(d2.addr);
		checkSel(expSel, readSel(),
			~(expSel.scr0 | expSel.scr1 | expSel.obj | expSel.snd | expSel.lth0 | expSel.lth1),
			nBufEn);
		checkPhase({d2.clk2H, d3.clk2H, ~d3.clk2H, ~d2.clk2H}, {me, subE, mq, subQ});
		checkIrq(modelIrqN, nIrq);
		checkRes(modelCnt < expireCount, nRes);
	endtask

	initial begin
		drive_t d;
		rst       = 1'b1;
		clk2H     = 1'b0;
		nWe       = 1'b1;
		nVblk     = 1'b1;
		addr      = '0;
		modelIrqN = 1'b1;
		modelCnt  = 0;
		vblkTimer = 20;
		ackDue    = -1;
		void'($urandom(14));
		for (int cycle = 0; cycle < totalCycles; cycle++) begin
			@(posedge clk6M);
			pickInputs(cycle, d);
			rst   <= (cycle < resetCycles - 1);
			clk2H <= d.clk2H;
			nWe   <= d.nWe;
			nVblk <= d.nVblk;
			addr  <= d.addr;
			hist.push_front(d);
			if (hist.size() > 4) void'(hist.pop_back());
			@(negedge clk6M);
			// Last reset edge, everything parked inactive
			if (cycle == resetCycles - 1) begin
				checkSel('0, readSel(), 1'b1, nBufEn);
				checkPhase(4'b0011, {me, subE, mq, subQ});
				checkIrq(1'b1, nIrq);
				checkRes(1'b1, nRes);
			end
			if (cycle == phaseCStart && nRes !== 1'b0) begin
				abortRun("watchdog did not expire while kicks were held off");
			end
			if (cycle >= firstCheck) checkCycle();
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/cus47Top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sub86_macros.svh"

//////////////////////////////////////////////////////////////////////
// CUS47 bus glue for the secondary CPU
//////////////////////////////////////////////////////////////////////

module cus47Top import sub86Pkg::*; (
	input  wire                     clk6M,
	input  wire                     rst,
	input  wire                     clk2H,
	input  wire                     nWe,
	input  wire                     nVblk,
	input  wire [`ADDR_HI:`ADDR_LO] addr,
	output wire                     nRes,
	output wire                     nIrq,
	output wire                     mq,
	output wire                     me,
	output wire                     subE,
	output wire                     subQ,
	output wire                     nScr0,
	output wire                     nScr1,
	output wire                     nObj,
	output wire                     nSnd,
	output wire                     nSpgm,
	output wire                     nMpgm,
	output wire                     bank,
	output wire                     nLth0,
	output wire                     nLth1,
	output wire                     nLth2,
	output wire                     nBufEn
);

	// Sampled bus
	logic [`ADDR_HI:`ADDR_LO] addrQ;
	logic                     weQ;
	logic                     vblkFall;

	// 2H delay taps
	logic ckB;
	logic ckC;

	// Decoder results
	region_e region;
	sel_t    sel;

	busSampler busSampler_i (
		.clk6M    (clk6M),
		.rst      (rst),
		.clk2H    (clk2H),
		.nWe      (nWe),
		.nVblk    (nVblk),
		.addr     (addr),
		.addrQ    (addrQ),
		.weQ      (weQ),
		.vblkFall (vblkFall),
		.ckB      (ckB),
		.ckC      (ckC)
	);

	regionDecoder regionDecoder_i (
		.addrQ  (addrQ),
		.region (region),
		.sel    (sel)
	);

	irqWatchdog irqWatchdog_i (
		.clk6M    (clk6M),
		.rst      (rst),
		.vblkFall (vblkFall),
		.weQ      (weQ),
		.region   (region),
		.nIrq     (nIrq),
		.nRes     (nRes)
	);

	busOutputStage busOutputStage_i (
		.clk6M  (clk6M),
		.rst    (rst),
		.sel    (sel),
		.ckB    (ckB),
		.ckC    (ckC),
		.nScr0  (nScr0),
		.nScr1  (nScr1),
		.nObj   (nObj),
		.nSnd   (nSnd),
		.nSpgm  (nSpgm),
		.nMpgm  (nMpgm),
		.bank   (bank),
		.nLth0  (nLth0),
		.nLth1  (nLth1),
		.nLth2  (nLth2),
		.nBufEn (nBufEn),
		.mq     (mq),
		.me     (me),
		.subE   (subE),
		.subQ   (subQ)
	);

endmodule

`default_nettype wire

//--- src/busOutputStage.sv
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Output stage
// All selects and CPU phases leave on the same clk6M edge
//////////////////////////////////////////////////////////////////////

module busOutputStage import sub86Pkg::*; (
	input  wire       clk6M,
	input  wire       rst,
	input  wire sel_t sel,
	input  wire       ckB,
	input  wire       ckC,
	output logic      nScr0,
	output logic      nScr1,
	output logic      nObj,
	output logic      nSnd,
	output logic      nSpgm,
	output logic      nMpgm,
	output logic      bank,
	output logic      nLth0,
	output logic      nLth1,
	output logic      nLth2,
	output logic      nBufEn,
	output logic      mq,
	output logic      me,
	output logic      subE,
	output logic      subQ
);

	// Any device behind the data bus buffer
	logic busReq;

	assign busReq = sel.scr0 | sel.scr1 | sel.obj | sel.snd | sel.lth0 | sel.lth1;

	always_ff @(posedge clk6M) begin
		if (rst) begin
			nScr0  <= 1'b1;
			nScr1  <= 1'b1;
			nObj   <= 1'b1;
			nSnd   <= 1'b1;
			nSpgm  <= 1'b1;
			nMpgm  <= 1'b1;
			bank   <= 1'b0;
			nLth0  <= 1'b1;
			nLth1  <= 1'b1;
			nLth2  <= 1'b1;
			nBufEn <= 1'b1;
			// Clocks parked low, inverses high
			me     <= 1'b0;
			subQ   <= 1'b1;
			subE   <= 1'b0;
			mq     <= 1'b1;
		end else begin
			// Selects leave active low
			nScr0  <= ~sel.scr0;
			nScr1  <= ~sel.scr1;
			nObj   <= ~sel.obj;
			nSnd   <= ~sel.snd;
			nSpgm  <= ~sel.spgm;
			nMpgm  <= ~sel.mpgm;
			// Tile bank strobe stays active high
			bank   <= sel.bank;
			nLth0  <= ~sel.lth0;
			nLth1  <= ~sel.lth1;
			nLth2  <= ~sel.lth2;
			nBufEn <= ~busReq;
			// E and Q pairs from the two 2H samples
			me     <= ckB;
			subQ   <= ~ckB;
			subE   <= ckC;
			mq     <= ~ckC;
		end
	end

endmodule

`default_nettype wire

//--- src/irqWatchdog.sv
`timescale 1ns/1ps
`default_nettype none

`include "sub86_macros.svh"

//////////////////////////////////////////////////////////////////////
// Vblank interrupt latch and watchdog
//////////////////////////////////////////////////////////////////////

module irqWatchdog import sub86Pkg::*; (
	input  wire          clk6M,
	input  wire          rst,
	input  wire          vblkFall,
	input  wire          weQ,
	input  wire region_e region,
	output logic         nIrq,
	output logic         nRes
);

	// Vblank fall count since the last kick
	logic [`WATCHDOG_WIDTH-1:0] wdogCnt;

	// Qualified write strobes
	logic irqAck;
	logic kick;

	// Top bit reached, counter holds
	logic expired;

	assign irqAck  = weQ && (region == regIrqAck);
	assign kick    = weQ && (region == regWdogKick);
	assign expired = wdogCnt[`WATCHDOG_WIDTH-1];

	// Interrupt latch
	// Set on vblank fall, cleared by the ack write
	always_ff @(posedge clk6M) begin
		if (rst) begin
			nIrq <= 1'b1;
		end else if (vblkFall) begin
			// New vblank beats a late ack
			nIrq <= 1'b0;
		end else if (irqAck) begin
			nIrq <= 1'b1;
		end
	end

	// Watchdog counter
	always_ff @(posedge clk6M) begin
		if (rst) begin
			wdogCnt <= '0;
		end else if (kick) begin
			// Kick wins over a same-cycle vblank
			wdogCnt <= '0;
		end else if (vblkFall && !expired) begin
			wdogCnt <= wdogCnt + 1'b1;
		end
	end

	// Reset line follows the counter top bit
	assign nRes = ~expired;

	// Interrupt only asserted right after a vblank edge
	irqFallAfterVblank: assert property (@(posedge clk6M) disable iff (rst)
		$fell(nIrq) |-> $past(vblkFall));

	// Once expired, only a kick releases the reset line
	resHeldUntilKick: assert property (@(posedge clk6M) disable iff (rst)
		(!nRes && !kick) |=> !nRes);

endmodule

`default_nettype wire

//--- src/regionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "sub86_macros.svh"

//////////////////////////////////////////////////////////////////////
// Memory map decoder
// Pure combinational from the sampled slice to the selects
//////////////////////////////////////////////////////////////////////

module regionDecoder import sub86Pkg::*; (
	input  wire [`ADDR_HI:`ADDR_LO] addrQ,
	output region_e                 region,
	output sel_t                    sel
);

	// Base addresses of the 1 KB windows
	localparam logic [15:0] baseSnd  = 16'h4000;
	localparam logic [15:0] baseKick = 16'h8000;
	localparam logic [15:0] baseAck  = 16'h8400;
	localparam logic [15:0] baseBank = 16'h8C00;
	localparam logic [15:0] baseLth0 = 16'h9000;
	localparam logic [15:0] baseLth1 = 16'h9400;
	localparam logic [15:0] baseLth2 = 16'hA000;

	// Chip selects
	always_comb begin
		sel = '0;

		// 8 KB blocks from the top three bits
		case (addrQ[`ADDR_HI -: 3])
			// 0000h-1FFFh
			3'b000: sel.scr0 = 1'b1;
			// 2000h-3FFFh
			3'b001: sel.scr1 = 1'b1;
			// 4000h-5FFFh
			3'b010: sel.obj = 1'b1;
			// 6000h-7FFFh
			3'b011: sel.spgm = 1'b1;
			// 8000h-FFFFh is the whole upper half
			default: sel.mpgm = 1'b1;
		endcase

		// Shared sound RAM sits inside the sprite block
		sel.snd = (addrQ == baseSnd[`ADDR_HI:`ADDR_LO]);

		// Write-only latches inside the main ROM space
		sel.bank = (addrQ == baseBank[`ADDR_HI:`ADDR_LO]);
		sel.lth0 = (addrQ == baseLth0[`ADDR_HI:`ADDR_LO]);
		sel.lth1 = (addrQ == baseLth1[`ADDR_HI:`ADDR_LO]);
		// Back colour latch at A000h
		sel.lth2 = (addrQ == baseLth2[`ADDR_HI:`ADDR_LO]);
	end

	// Window class for the interrupt and watchdog logic
	always_comb begin
		if (addrQ == baseAck[`ADDR_HI:`ADDR_LO]) begin
			// 8400h acknowledges the vblank interrupt
			region = regIrqAck;
		end else if (addrQ == baseKick[`ADDR_HI:`ADDR_LO]) begin
			// 8000h-83FFh clears the watchdog
			region = regWdogKick;
		end else begin
			region = regOther;
		end
	end

endmodule

`default_nettype wire

//--- src/busSampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "sub86_macros.svh"

//////////////////////////////////////////////////////////////////////
// Input stage
// Samples the bus, vblank and 2H on clk6M
//////////////////////////////////////////////////////////////////////

module busSampler (
	input  wire                      clk6M,
	input  wire                      rst,
	input  wire                      clk2H,
	input  wire                      nWe,
	input  wire                      nVblk,
	input  wire [`ADDR_HI:`ADDR_LO]  addr,
	output logic [`ADDR_HI:`ADDR_LO] addrQ,
	output logic                     weQ,
	output logic                     vblkFall,
	output logic                     ckB,
	output logic                     ckC
);

	// Last vblank level seen, for edge detection
	logic nVblkQ;

	// Address slice sampled every cycle
	always_ff @(posedge clk6M) begin
		addrQ <= addr;
	end

	always_ff @(posedge clk6M) begin
		if (rst) begin
			weQ      <= 1'b0;
			nVblkQ   <= 1'b1;
			vblkFall <= 1'b0;
			ckB      <= 1'b0;
			ckC      <= 1'b0;
		end else begin
			// Write strobe turned active high
			weQ      <= ~nWe;
			nVblkQ   <= nVblk;
			// High in the last sample, low now
			vblkFall <= nVblkQ & ~nVblk;
			// Two-stage 2H delay line, as in the quad latch
			ckB      <= clk2H;
			ckC      <= ckB;
		end
	end

	// Edge pulse lasts a single clk6M cycle
	vblkFallSingle: assert property (@(posedge clk6M) disable iff (rst)
		vblkFall |=> !vblkFall);

endmodule

`default_nettype wire

//--- src/sub86Pkg.sv
`default_nettype none

//////////////////////////////////////////////////////////////////////
// Types shared by the secondary CPU bus glue
//////////////////////////////////////////////////////////////////////

package sub86Pkg;

	// Windows that need an action beyond a chip select
	// Anything not listed falls into regOther
	typedef enum logic [1:0] {
		regOther    = 2'd0,
		regWdogKick = 2'd1,
		regIrqAck   = 2'd2
	} region_e;

	// Active-high chip selects
	// Several bits may be set at once where windows overlap
	typedef struct packed {
		// Video RAM planes
		logic scr0;
		logic scr1;
		// Sprite RAM and the sound CPU shared RAM
		logic obj;
		logic snd;
		// Sub and main program ROMs
		logic spgm;
		logic mpgm;
		// Tile bank latch
		logic bank;
		// Scroll latches and back colour
		logic lth0;
		logic lth1;
		logic lth2;
	} sel_t;

endpackage

`default_nettype wire

//--- include/sub86_macros.svh
`ifndef SUB86_MACROS_SVH
`define SUB86_MACROS_SVH

// Watchdog counter width in vblank counts
`define WATCHDOG_WIDTH 4

// Upper and lower bits of the decoded address slice
// Each slice code covers one 1 KB window
`define ADDR_HI 15
`define ADDR_LO 10

`endif
